// File: sources.f
+incdir+rtl
+incdir+sim
rtl/aes_dec_pkg.sv
rtl/inv_sbox_rom.sv
rtl/block_capture.sv
rtl/round_control.sv
rtl/inv_round_datapath.sv
rtl/result_output.sv
rtl/aes_dec_top.sv
sim/aes_dec_asserts.sv
sim/aes_dec_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the AES-256 decryption testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module aes_dec_tb \
    -f sources.f \
    -o aes_dec_sim

# Keep running past assertion errors so the closing report is printed
./obj_dir/aes_dec_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx 'All tests passed!' sim.log; then
    echo "Simulation run succeeded"
else
    echo "Simulation run did not succeed, see sim.log"
    exit 1
fi

// File: sim/aes_dec_tb.sv
//--------------------
// Testbench for the AES-256 decryption core.
// Serves random round keys by key_addr, sends random blocks and leaves
// all checking to the bound assertion module.
//--------------------
`include "aes_dec_params.svh"

module aes_dec_tb;

    localparam int num_tests  = 6;
    localparam int seed       = 75;
    // Per test one latency plus idle gaps, plus reset and margin
    localparam int max_cycles = num_tests * (`AES_LATENCY + 10) + 50;

    logic                        clk;
    logic                        resetn;
    logic                        in_valid;
    logic [127:0]                in_data;
    logic [127:0]                key;
    logic [`AES_KEY_ADDR_W-1:0]  key_addr;
    logic                        busy;
    logic                        out_valid;
    logic [127:0]                out_data;

    logic [127:0] key_table [`AES_NUM_ROUNDS+1];
    int           cycles;
    int           tests_done;

    aes_dec_top DUT (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .key       (key),
        .key_addr  (key_addr),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    bind aes_dec_top aes_dec_asserts u_asserts (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Key source answers the current key address
    always @(negedge clk)
        key = key_table[key_addr];

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Simulation timed out after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [127:0] random_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic fill_key_table();
        for (int i = 0; i <= `AES_NUM_ROUNDS; i++)
            key_table[i] = random_word();
    endtask

    // One block through the core, optionally a second offer while busy
    task automatic decrypt_one(input bit offer_while_busy);
        int gap;
        fill_key_table();
        @(negedge clk);
        in_valid = 1'b1;
        in_data  = random_word();
        @(negedge clk);
        in_valid = 1'b0;
        // Junk on the data lines
        in_data  = random_word();
        if (offer_while_busy)
        begin
            gap = 20 + int'($urandom % 200);
            repeat (gap) @(negedge clk);
            in_valid = 1'b1;
            in_data  = random_word();
            @(negedge clk);
            in_valid = 1'b0;
        end
        while (!out_valid)
            @(negedge clk);
        tests_done++;
        repeat (1 + $urandom % 4) @(negedge clk);
    endtask

    initial
    begin
        resetn     = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        key        = '0;
        cycles     = 0;
        tests_done = 0;
        for (int i = 0; i <= `AES_NUM_ROUNDS; i++)
            key_table[i] = '0;
        void'($urandom(seed));

        repeat (5) @(negedge clk);
        resetn = 1'b1;
        repeat (2) @(negedge clk);

        // Odd tests also try a block during the run
        for (int t = 0; t < num_tests; t++)
            decrypt_one(t % 2 == 1);

        $display("Tests run: %0d, assertion failures: %0d",
                 tests_done, DUT.u_asserts.fail_count);
        if (DUT.u_asserts.fail_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: sim/aes_fwd_model.svh
//--------------------
// Forward AES-256 cipher for re-encrypting decrypted blocks.
// Included inside the checker module; byte i of a block is bits [8i+7:8i].
//--------------------
`ifndef AES_FWD_MODEL_SVH
`define AES_FWD_MODEL_SVH

`include "aes_dec_params.svh"

// Forward S-box, row n holds entries 16n..16n+15 from the top byte down
localparam logic [127:0] fwd_sbox [16] = '{
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
};

// Multiply by x modulo x^8+x^4+x^3+x+1
function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [7:0] sbox_byte(input logic [7:0] b);
    logic [127:0] row;
    // Wanted entry moved to the top byte
    row = fwd_sbox[b[7:4]] << {b[3:0], 3'b000};
    return row[127:120];
endfunction

// SubBytes and ShiftRows, row r takes its byte from column c+r
function automatic logic [127:0] sub_shift(input logic [127:0] s);
    logic [127:0] res;
    for (int c = 0; c < 4; c++)
    begin
        for (int r = 0; r < 4; r++)
            res[32*c + 8*r +: 8] = sbox_byte(s[32*((c + r) % 4) + 8*r +: 8]);
    end
    return res;
endfunction

function automatic logic [127:0] mix_columns(input logic [127:0] s);
    logic [127:0] res;
    logic [7:0]   a0, a1, a2, a3;
    for (int c = 0; c < 4; c++)
    begin
        a0 = s[32*c +: 8];
        a1 = s[32*c + 8 +: 8];
        a2 = s[32*c + 16 +: 8];
        a3 = s[32*c + 24 +: 8];
        // Rows of the 02 03 01 01 circulant
        res[32*c +: 8]      = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
        res[32*c + 8 +: 8]  = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
        res[32*c + 16 +: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
        res[32*c + 24 +: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    end
    return res;
endfunction

// Round key i is the key served for key address i
function automatic logic [127:0] encrypt_block(input logic [127:0] pt,
                                               input logic [`AES_NUM_ROUNDS:0][127:0] rk);
    logic [127:0] s;
    s = pt ^ rk[0];
    for (int r = 1; r < `AES_NUM_ROUNDS; r++)
        s = mix_columns(sub_shift(s)) ^ rk[r];
    // Last round skips MixColumns
    s = sub_shift(s) ^ rk[`AES_NUM_ROUNDS];
    return s;
endfunction

`endif

// File: sim/aes_dec_asserts.sv
//--------------------
// Checker bound to the decryption core top level.
// Records accepted blocks and served round keys, re-encrypts each
// result and checks latency, key order and reset values.
//--------------------
`include "aes_dec_params.svh"

module aes_dec_asserts
(
    input logic                        clk,
    input logic                        resetn,
    input logic                        in_valid,
    input logic [127:0]                in_data,
    input logic [127:0]                key,
    input logic [`AES_KEY_ADDR_W-1:0]  key_addr,
    input logic                        busy,
    input logic                        out_valid,
    input logic [127:0]                out_data
);

    `include "aes_fwd_model.svh"

    // Read by the testbench for its closing report
    int fail_count = 0;

    logic                               accept;
    logic                               pending;
    int                                 lat_cnt;
    logic                               zero_seen;
    logic                               prev_busy;
    logic [`AES_KEY_ADDR_W-1:0]         prev_addr;
    logic                               prev_rstn;
    logic                               rst_seen;
    logic [127:0]                       cipher_seen;
    logic [`AES_NUM_ROUNDS:0][127:0]    keys_seen;
    logic [127:0]                       reencrypted;

    // Blocks offered while busy are not taken
    assign accept = in_valid && !busy;

    assign reencrypted = encrypt_block(out_data, keys_seen);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            pending   <= 1'b0;
            lat_cnt   <= 0;
            zero_seen <= 1'b0;
            prev_busy <= 1'b0;
            prev_addr <= '0;
        end
        else
        begin
            if (accept)
            begin
                pending   <= 1'b1;
                lat_cnt   <= 1;
                zero_seen <= 1'b0;
            end
            else
            begin
                if (out_valid)
                    pending <= 1'b0;
                // Cycles since acceptance
                if (pending)
                    lat_cnt <= lat_cnt + 1;
                if (busy && key_addr == 0)
                    zero_seen <= 1'b1;
            end
            prev_busy <= busy;
            prev_addr <= key_addr;
        end
    end

    // Ciphertext, keys by address, reset history
    always_ff @(posedge clk)
    begin
        if (accept)
            cipher_seen <= in_data;
        if (busy)
            keys_seen[key_addr] <= key;
        prev_rstn <= resetn;
        if (!resetn)
            rst_seen <= 1'b1;
    end

    a_decrypt: assert property (@(posedge clk) disable iff (!resetn)
        out_valid |-> (reencrypted == cipher_seen))
    else
    begin
        fail_count++;
        $error("Mismatch at %0t: result does not re-encrypt to the ciphertext", $time);
    end

    // Exact latency, single pulse, and nothing for a dropped block
    a_latency: assert property (@(posedge clk) disable iff (!resetn)
        out_valid == (pending && lat_cnt == `AES_LATENCY))
    else
    begin
        fail_count++;
        $error("out_valid at the wrong cycle, %0d cycles after acceptance at %0t",
               lat_cnt, $time);
    end

    a_key_start: assert property (@(posedge clk) disable iff (!resetn)
        accept |=> (key_addr == `AES_NUM_ROUNDS))
    else
    begin
        fail_count++;
        $error("Mismatch at %0t: key address did not start at the top index", $time);
    end

    // Hold or step down by one
    a_key_step: assert property (@(posedge clk) disable iff (!resetn)
        (busy && prev_busy) |->
            (key_addr == prev_addr || int'(key_addr) + 1 == int'(prev_addr)))
    else
    begin
        fail_count++;
        $error("Mismatch at %0t: key address jumped from %0d to %0d",
               $time, prev_addr, key_addr);
    end

    a_key_end: assert property (@(posedge clk) disable iff (!resetn)
        out_valid |-> zero_seen)
    else
    begin
        fail_count++;
        $error("Result came before key address 0 was used at %0t", $time);
    end

    // Second reset cycle onward, plus the first cycle after release
    a_reset: assert property (@(posedge clk)
        (rst_seen && !prev_rstn) |-> (!busy && !out_valid && out_data == '0))
    else
    begin
        fail_count++;
        $error("Mismatch at %0t: outputs not idle around reset", $time);
    end

endmodule

// File: rtl/aes_dec_top.sv
//------------------
// Iterative AES-256 decryption core.
// Pulse in_valid with a block while busy is low, serve key for key_addr
// in the same cycle, and collect out_data on the out_valid pulse.
//------------------
`include "aes_dec_params.svh"

module aes_dec_top
    import aes_dec_pkg::*;
(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        in_valid,
    input  logic [127:0]                in_data,
    input  logic [127:0]                key,
    output logic [`AES_KEY_ADDR_W-1:0]  key_addr,
    output logic                        busy,
    output logic                        out_valid,
    output logic [127:0]                out_data
);

    // Capture to control and datapath
    logic       load;
    state_t     cap_state;

    // Control to datapath and output
    round_op_e  op;
    logic       done;

    // Datapath and S-box
    state_t     state;
    byte_t      sbox_addr;
    byte_t      sbox_data;

    // Input block and acceptance
    block_capture u_capture (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .busy      (busy),
        .in_data   (in_data),
        .load      (load),
        .cap_state (cap_state)
    );

    // Round sequencing and key index
    round_control u_control (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .op       (op),
        .key_addr (key_addr),
        .busy     (busy),
        .done     (done)
    );

    inv_round_datapath u_datapath (
        .clk       (clk),
        .resetn    (resetn),
        .op        (op),
        .cap_state (cap_state),
        .key       (key),
        .sbox_data (sbox_data),
        .sbox_addr (sbox_addr),
        .state     (state)
    );

    // One lookup per cycle, one cycle latency
    inv_sbox_rom u_sbox (
        .clk       (clk),
        .sbox_addr (sbox_addr),
        .sbox_data (sbox_data)
    );

    result_output u_output (
        .clk       (clk),
        .resetn    (resetn),
        .done      (done),
        .state     (state),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: rtl/result_output.sv
//------------------
// Output side of the decryption core.
// Takes the final state on done and returns it as a 128-bit block,
// flagged by a single out_valid cycle; the block holds until the next.
//------------------
`include "aes_dec_params.svh"

module result_output
    import aes_dec_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         done,
    input  state_t       state,
    output logic         out_valid,
    output logic [127:0] out_data
);

    localparam int num_cols = `AES_BLOCK_BYTES / 4;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end
        else
        begin
            // One-cycle pulse
            out_valid <= done;
            if (done)
            begin
                // Same byte order as the input block
                for (int c = 0; c < num_cols; c++)
                begin
                    for (int r = 0; r < 4; r++)
                        out_data[32*c + 8*r +: 8] <= state[4*c + r];
                end
            end
        end
    end

endmodule

// File: rtl/inv_round_datapath.sv
//------------------
// State register and inverse round operations of the decryption core.
// Each cycle applies the operation selected by op; substitution streams
// the state through the external S-box ROM one byte per cycle.
//------------------
`include "aes_dec_params.svh"

module inv_round_datapath
    import aes_dec_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  round_op_e    op,
    input  state_t       cap_state,
    input  logic [127:0] key,
    input  byte_t        sbox_data,
    output byte_t        sbox_addr,
    output state_t       state
);

    localparam int num_cols = `AES_BLOCK_BYTES / 4;

    state_t key_state;
    state_t shifted;
    state_t mixed;
    state_t rotated;

    // Round key in the same byte order as the state
    assign key_state = key;

    assign shifted = inv_shift_rows(state);

    // Inverse mix, column by column
    always_comb
    begin
        for (int c = 0; c < num_cols; c++)
            mixed[4*c + 0 +: 4] = inv_mix_column(state[4*c +: 4]);
    end

    // Byte 0 leaves toward the ROM, the substituted byte enters at the top
    // The first byte in is stale and has left again after 17 cycles
    assign rotated = {sbox_data, state[`AES_BLOCK_BYTES-1:1]};

    assign sbox_addr = state[0];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= '0;
        else
        begin
            case (op)
                // New block plus initial round key
                op_load:
                    state <= cap_state ^ key_state;
                op_add_key:
                    state <= state ^ key_state;
                op_inv_shift:
                    state <= shifted;
                op_sub_byte:
                    state <= rotated;
                op_inv_mix:
                    state <= mixed;
                default:
                    state <= state;
            endcase
        end
    end

endmodule

// File: rtl/round_control.sv
//------------------
// Round sequencer of the decryption core.
// Started by load, it issues one datapath operation per cycle, walks the
// round keys from the top index down and flags done after the last round.
//------------------
`include "aes_dec_params.svh"

module round_control
    import aes_dec_pkg::*;
(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        load,
    output round_op_e                   op,
    output logic [`AES_KEY_ADDR_W-1:0]  key_addr,
    output logic                        busy,
    output logic                        done
);

    localparam logic [`AES_KEY_ADDR_W-1:0] last_round = `AES_NUM_ROUNDS;
    // 16 bytes plus one cycle of ROM latency
    localparam logic [4:0] last_byte = `AES_BLOCK_BYTES;

    ctrl_state_e                 fsm;
    ctrl_state_e                 fsm_next;
    logic [`AES_KEY_ADDR_W-1:0]  round;
    logic [4:0]                  byte_cnt;

    // Next state
    always_comb
    begin
        fsm_next = fsm;
        case (fsm)
            st_idle:
            begin
                if (load)
                    fsm_next = st_shift;
            end
            st_shift:
                fsm_next = st_sub;
            st_sub:
            begin
                if (byte_cnt == last_byte)
                    fsm_next = st_add;
            end
            st_add:
            begin
                // No inverse mix in the final round
                if (round == last_round)
                    fsm_next = st_done;
                else
                    fsm_next = st_mix;
            end
            st_mix:
                fsm_next = st_shift;
            st_done:
                fsm_next = st_idle;
            default:
                fsm_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            fsm      <= st_idle;
            round    <= '0;
            byte_cnt <= '0;
        end
        else
        begin
            fsm <= fsm_next;

            // Round 1 starts after load, later rounds after inv_mix
            if (fsm == st_idle && load)
                round <= 1;
            else if (fsm == st_mix)
                round <= round + 1'b1;
            else if (fsm == st_done)
                round <= '0;

            // Substitution byte count
            if (fsm == st_sub)
                byte_cnt <= byte_cnt + 1'b1;
            else
                byte_cnt <= '0;
        end
    end

    // Load also folds in the initial round key
    always_comb
    begin
        case (fsm)
            st_idle:  op = load ? op_load : op_hold;
            st_shift: op = op_inv_shift;
            st_sub:   op = op_sub_byte;
            st_add:   op = op_add_key;
            st_mix:   op = op_inv_mix;
            default:  op = op_hold;
        endcase
    end

    // Keys are consumed from index 14 down to 0
    assign key_addr = last_round - round;

    // Busy from acceptance through the last add_key
    assign busy = load || (fsm != st_idle && fsm != st_done);
    assign done = (fsm == st_done);

endmodule

// File: rtl/block_capture.sv
//------------------
// Input side of the decryption core.
// Takes a block when in_valid arrives while idle and presents it in
// state byte order, with a one-cycle load pulse.
//------------------
`include "aes_dec_params.svh"

module block_capture
    import aes_dec_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         in_valid,
    input  logic         busy,
    input  logic [127:0] in_data,
    output logic         load,
    output state_t       cap_state
);

    localparam int num_cols = `AES_BLOCK_BYTES / 4;

    logic accept;

    // Blocks offered during a run are dropped
    assign accept = in_valid && !busy;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            load <= 1'b0;
        else
            load <= accept;
    end

    // Column c is word c, row r is byte r of that word
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            for (int c = 0; c < num_cols; c++)
            begin
                for (int r = 0; r < 4; r++)
                    cap_state[4*c + r] <= in_data[32*c + 8*r +: 8];
            end
        end
    end

endmodule

// File: rtl/inv_sbox_rom.sv
//------------------
// Inverse AES S-box, 256 bytes with a registered read port.
// Data for an address appears one clock after it is presented.
//------------------
module inv_sbox_rom
(
    input  logic       clk,
    input  logic [7:0] sbox_addr,
    output logic [7:0] sbox_data
);

    // Row-major, eight entries per line
    localparam logic [7:0] inv_sbox [256] = '{
        8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
        8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
        8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
        8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
        8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
        8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
        8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
        8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
        8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
        8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
        8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
        8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
        8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
        8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
        8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
        8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
        8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
        8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
        8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
        8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
        8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
        8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
        8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
        8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
        8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
        8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
        8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
        8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
        8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
        8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
        8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
        8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
    };

    // Registered lookup, maps onto a block ROM
    always_ff @(posedge clk)
    begin
        sbox_data <= inv_sbox[sbox_addr];
    end

endmodule

// File: rtl/aes_dec_pkg.sv
//------------------
// Types and inverse-round helpers for the AES-256 decryption core.
// Imported by every RTL module except the S-box ROM.
//------------------
`include "aes_dec_params.svh"

package aes_dec_pkg;

    typedef logic [7:0] byte_t;

    // Byte 4*c+r holds row r of column c, byte i sits at bits [8i+7:8i]
    typedef byte_t [`AES_BLOCK_BYTES-1:0] state_t;

    // Datapath operation code
    typedef enum logic [2:0]
    {
        op_hold,
        op_load,
        op_add_key,
        op_inv_shift,
        op_sub_byte,
        op_inv_mix
    } round_op_e;

    // Round sequencer states
    typedef enum logic [2:0]
    {
        st_idle,
        st_shift,
        st_sub,
        st_add,
        st_mix,
        st_done
    } ctrl_state_e;

    // Product in GF(2^8), polynomial x^8+x^4+x^3+x+1
    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t x;
        acc = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ x;
            // xtime
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    // One column through the inverse mix matrix, row r in bits [8r+7:8r]
    function automatic logic [31:0] inv_mix_column(input logic [31:0] col);
        byte_t a0, a1, a2, a3;
        logic [31:0] res;
        a0 = col[7:0];
        a1 = col[15:8];
        a2 = col[23:16];
        a3 = col[31:24];
        res[7:0]   = gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09);
        res[15:8]  = gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d);
        res[23:16] = gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b);
        res[31:24] = gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e);
        return res;
    endfunction

    // Row r rotates right by r columns
    function automatic state_t inv_shift_rows(input state_t s);
        state_t res;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                res[4*c + r] = s[4*((c - r + 4) % 4) + r];
        end
        return res;
    endfunction

endpackage

// File: rtl/aes_dec_params.svh
//------------------
// Build constants of the AES-256 decryption core.
// Pulled in by the package, the RTL and the testbench files.
//------------------
`ifndef AES_DEC_PARAMS_SVH
`define AES_DEC_PARAMS_SVH

// Rounds after the initial AddRoundKey
`define AES_NUM_ROUNDS   14

// Bytes per 128-bit state
`define AES_BLOCK_BYTES  16

// Round key index 0..14
`define AES_KEY_ADDR_W   4

// Cycles from an accepted in_valid to out_valid
`define AES_LATENCY      282

`endif
